//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_region_track -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_region_track | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- box_outline_overlay.sv
`timescale 1ns/1ps

module box_outline_overlay (
    input  logic clk,
    input  logic reset,
    input  logic [region_track_pkg::COORD_W-1:0] draw_x_i,
    input  logic [region_track_pkg::COORD_W-1:0] draw_y_i,
    input  logic [region_track_pkg::PIX_W-1:0]   fb_pixel_i,
    input  logic [region_track_pkg::COORD_W-1:0] min_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] max_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] min_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] max_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::NUM_REGIONS-1:0] region_ok_i,
    input  logic highlight_i,
    output logic [region_track_pkg::PIX_W-1:0]   red_o,
    output logic [region_track_pkg::PIX_W-1:0]   green_o,
    output logic [region_track_pkg::PIX_W-1:0]   blue_o
);

    import region_track_pkg::*;

    logic [NUM_REGIONS-1:0] on_row;
    logic [NUM_REGIONS-1:0] on_col;
    logic                   hit;
    logic                   paint;

    //////////////////////////////////////////////////
    // Outline test
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            // Top or bottom edge, inside the x span
            on_row[i] = (draw_y_i == min_y_i[i] || draw_y_i == max_y_i[i]) &&
                        draw_x_i >= min_x_i[i] && draw_x_i <= max_x_i[i];
            // Left or right edge, inside the y span
            on_col[i] = (draw_x_i == min_x_i[i] || draw_x_i == max_x_i[i]) &&
                        draw_y_i >= min_y_i[i] && draw_y_i <= max_y_i[i];
        end
    end

    // Only boxes that passed the area filter count
    assign hit   = |((on_row | on_col) & region_ok_i);
    assign paint = hit & highlight_i;

    // Output colors
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else if (paint) begin
            red_o   <= PIX_FULL;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            // Plain gray from the frame buffer
            red_o   <= fb_pixel_i;
            green_o <= fb_pixel_i;
            blue_o  <= fb_pixel_i;
        end
    end

endmodule

//--- filelist.f
region_track_pkg.sv
frame_sequencer.sv
region_box_bank.sv
region_area_filter.sv
box_outline_overlay.sv
pixel_write_formatter.sv
region_track_top.sv
tb_region_track.sv

//--- frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic frame_vsync_i,
    output logic latch_o
);

    import region_track_pkg::*;

    logic                 vsync_q0;
    logic                 vsync_q1;
    logic                 frame_edge;
    logic [SEQ_CNT_W-1:0] edge_cnt;

    // Two-stage sync of vsync
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vsync_q0 <= 1'b0;
            vsync_q1 <= 1'b0;
        end else begin
            vsync_q0 <= frame_vsync_i;
            vsync_q1 <= vsync_q0;
        end
    end

    // Falling edge of the synced vsync
    assign frame_edge = vsync_q1 & ~vsync_q0;

    // Latch on every fifth frame edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edge_cnt <= '0;
            latch_o  <= 1'b0;
        end else begin
            latch_o <= 1'b0;
            if (frame_edge) begin
                if (edge_cnt == SEQ_CNT_W'(LATCH_EVERY - 1)) begin
                    edge_cnt <= '0;
                    latch_o  <= 1'b1;
                end else begin
                    edge_cnt <= edge_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- pixel_write_formatter.sv
`timescale 1ns/1ps

module pixel_write_formatter (
    input  logic clk,
    input  logic reset,
    input  logic pixel_valid_i,
    input  logic [region_track_pkg::COORD_W-1:0] pixel_x_i,
    input  logic [region_track_pkg::COORD_W-1:0] pixel_y_i,
    input  logic [region_track_pkg::CAM_W-1:0]   pixel_data_i,
    input  logic [region_track_pkg::PIX_W-1:0]   brightness_i,
    input  logic mask_mode_i,
    input  logic skin_i,
    output logic fb_we_o,
    output logic [region_track_pkg::ADDR_W-1:0]  fb_addr_o,
    output logic [region_track_pkg::PIX_W-1:0]   fb_data_o
);

    import region_track_pkg::*;

    logic [2*PIX_W-1:0] scaled;
    logic [ADDR_W-1:0]  pix_addr;
    logic [PIX_W-1:0]   pix_data;

    // Brightness as a fraction of 128
    assign scaled   = pixel_data_i[CAM_W-1:1] * brightness_i;
    assign pix_addr = ADDR_W'(pixel_y_i) * ADDR_W'(FRAME_W) + ADDR_W'(pixel_x_i);

    always_comb begin
        if (mask_mode_i) begin
            pix_data = skin_i ? MASK_SKIN : MASK_BG;
        end else begin
            pix_data = scaled[2*PIX_W-1:PIX_W];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fb_we_o <= 1'b0;
        end else begin
            fb_we_o <= pixel_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid_i) begin
            fb_addr_o <= pix_addr;
            fb_data_o <= pix_data;
        end
    end

endmodule

//--- region_area_filter.sv
`timescale 1ns/1ps

module region_area_filter (
    input  logic clk,
    input  logic reset,
    input  logic [region_track_pkg::COORD_W-1:0]  min_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0]  max_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0]  min_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0]  max_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::THRESH_W-1:0] area_thresh_i,
    output logic [region_track_pkg::NUM_REGIONS-1:0] region_ok_o
);

    import region_track_pkg::*;

    logic [SPAN_W-1:0]   width  [NUM_REGIONS];
    logic [SPAN_W-1:0]   height [NUM_REGIONS];
    logic [AREA_W-1:0]   area   [NUM_REGIONS];
    logic [THRESH_W-1:0] thresh;

    // Zero on the switches selects the default
    assign thresh = (area_thresh_i != '0) ? area_thresh_i : DEFAULT_AREA_THRESH;

    //////////////////////////////////////////////////
    // Box size per region
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (min_x_i[i] != NO_BOX && max_x_i[i] >= min_x_i[i] &&
                min_y_i[i] != NO_BOX && max_y_i[i] >= min_y_i[i]) begin
                width[i]  = SPAN_W'(max_x_i[i]) - SPAN_W'(min_x_i[i]) + 1'b1;
                height[i] = SPAN_W'(max_y_i[i]) - SPAN_W'(min_y_i[i]) + 1'b1;
                area[i]   = width[i] * height[i];
            end else begin
                width[i]  = '0;
                height[i] = '0;
                area[i]   = '0;
            end
        end
    end

    // Pass flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            region_ok_o <= '0;
        end else begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                region_ok_o[i] <= (area[i] >= AREA_W'(thresh));
            end
        end
    end

endmodule

//--- region_box_bank.sv
`timescale 1ns/1ps

module region_box_bank (
    input  logic clk,
    input  logic reset,
    input  logic latch_i,
    input  logic [region_track_pkg::COORD_W-1:0] box_min_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_max_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_min_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_max_y_i [region_track_pkg::NUM_REGIONS],
    output logic [region_track_pkg::COORD_W-1:0] min_x_o [region_track_pkg::NUM_REGIONS],
    output logic [region_track_pkg::COORD_W-1:0] max_x_o [region_track_pkg::NUM_REGIONS],
    output logic [region_track_pkg::COORD_W-1:0] min_y_o [region_track_pkg::NUM_REGIONS],
    output logic [region_track_pkg::COORD_W-1:0] max_y_o [region_track_pkg::NUM_REGIONS]
);

    import region_track_pkg::*;

    //////////////////////////////////////////////////
    // Latched boxes
    //////////////////////////////////////////////////

    // All 48 coordinates load together so the display never
    // mixes boxes from two different frames
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                min_x_o[i] <= NO_BOX;
                max_x_o[i] <= '0;
                min_y_o[i] <= NO_BOX;
                max_y_o[i] <= '0;
            end
        end else if (latch_i) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                min_x_o[i] <= box_min_x_i[i];
                max_x_o[i] <= box_max_x_i[i];
                min_y_o[i] <= box_min_y_i[i];
                max_y_o[i] <= box_max_y_i[i];
            end
        end
    end

endmodule

//--- region_track_pkg.sv
package region_track_pkg;

    //////////////////////////////////////////////////
    // Frame geometry and datapath widths
    //////////////////////////////////////////////////

    localparam int FRAME_W  = 640;
    localparam int COORD_W  = 10;
    localparam int ADDR_W   = 19;
    localparam int CAM_W    = 8;
    localparam int PIX_W    = 7;

    // Box span and area, one bit wider than the coordinate difference
    localparam int SPAN_W   = 11;
    localparam int AREA_W   = 22;
    localparam int THRESH_W = 15;

    // 4 by 3 grid of tracked regions
    localparam int NUM_REGIONS = 12;

    //////////////////////////////////////////////////
    // Sentinels and tuning
    //////////////////////////////////////////////////

    // Minimum coordinate of a region that saw no pixel
    localparam logic [COORD_W-1:0] NO_BOX = 10'd641;

    localparam logic [THRESH_W-1:0] DEFAULT_AREA_THRESH = 15'd16;

    // Frame edges per box latch
    localparam int LATCH_EVERY = 5;
    localparam int SEQ_CNT_W   = 3;

    // Frame-buffer values in mask mode
    localparam logic [PIX_W-1:0] MASK_SKIN = 7'h00;
    localparam logic [PIX_W-1:0] MASK_BG   = 7'h3F;

    localparam logic [PIX_W-1:0] PIX_FULL  = 7'h7F;

endpackage

//--- region_track_top.sv
`timescale 1ns/1ps

module region_track_top (
    input  logic clk,
    input  logic reset,

    // Captured pixel stream
    input  logic pixel_valid_i,
    input  logic [region_track_pkg::COORD_W-1:0] pixel_x_i,
    input  logic [region_track_pkg::COORD_W-1:0] pixel_y_i,
    input  logic [region_track_pkg::CAM_W-1:0]   pixel_data_i,
    input  logic [region_track_pkg::PIX_W-1:0]   brightness_i,
    input  logic mask_mode_i,
    input  logic skin_i,

    input  logic frame_vsync_i,

    // Boxes from the capture side
    input  logic [region_track_pkg::COORD_W-1:0] box_min_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_max_x_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_min_y_i [region_track_pkg::NUM_REGIONS],
    input  logic [region_track_pkg::COORD_W-1:0] box_max_y_i [region_track_pkg::NUM_REGIONS],

    // Display side
    input  logic [region_track_pkg::COORD_W-1:0] draw_x_i,
    input  logic [region_track_pkg::COORD_W-1:0] draw_y_i,
    input  logic [region_track_pkg::PIX_W-1:0]   fb_pixel_i,

    // Switches
    input  logic [region_track_pkg::THRESH_W-1:0] area_thresh_i,
    input  logic highlight_i,

    output logic fb_we_o,
    output logic [region_track_pkg::ADDR_W-1:0]  fb_addr_o,
    output logic [region_track_pkg::PIX_W-1:0]   fb_data_o,
    output logic [region_track_pkg::PIX_W-1:0]   red_o,
    output logic [region_track_pkg::PIX_W-1:0]   green_o,
    output logic [region_track_pkg::PIX_W-1:0]   blue_o
);

    import region_track_pkg::*;

    logic                   latch;
    logic [COORD_W-1:0]     min_x [NUM_REGIONS];
    logic [COORD_W-1:0]     max_x [NUM_REGIONS];
    logic [COORD_W-1:0]     min_y [NUM_REGIONS];
    logic [COORD_W-1:0]     max_y [NUM_REGIONS];
    logic [NUM_REGIONS-1:0] region_ok;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    pixel_write_formatter u_formatter (
        .clk           (clk),
        .reset         (reset),
        .pixel_valid_i (pixel_valid_i),
        .pixel_x_i     (pixel_x_i),
        .pixel_y_i     (pixel_y_i),
        .pixel_data_i  (pixel_data_i),
        .brightness_i  (brightness_i),
        .mask_mode_i   (mask_mode_i),
        .skin_i        (skin_i),
        .fb_we_o       (fb_we_o),
        .fb_addr_o     (fb_addr_o),
        .fb_data_o     (fb_data_o)
    );

    //////////////////////////////////////////////////
    // Box tracking and overlay
    //////////////////////////////////////////////////

    frame_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .frame_vsync_i (frame_vsync_i),
        .latch_o       (latch)
    );

    region_box_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .latch_i     (latch),
        .box_min_x_i (box_min_x_i),
        .box_max_x_i (box_max_x_i),
        .box_min_y_i (box_min_y_i),
        .box_max_y_i (box_max_y_i),
        .min_x_o     (min_x),
        .max_x_o     (max_x),
        .min_y_o     (min_y),
        .max_y_o     (max_y)
    );

    region_area_filter u_filter (
        .clk           (clk),
        .reset         (reset),
        .min_x_i       (min_x),
        .max_x_i       (max_x),
        .min_y_i       (min_y),
        .max_y_i       (max_y),
        .area_thresh_i (area_thresh_i),
        .region_ok_o   (region_ok)
    );

    box_outline_overlay u_overlay (
        .clk         (clk),
        .reset       (reset),
        .draw_x_i    (draw_x_i),
        .draw_y_i    (draw_y_i),
        .fb_pixel_i  (fb_pixel_i),
        .min_x_i     (min_x),
        .max_x_i     (max_x),
        .min_y_i     (min_y),
        .max_y_i     (max_y),
        .region_ok_i (region_ok),
        .highlight_i (highlight_i),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o)
    );

endmodule

//--- tb_region_track.sv
`timescale 1ns/1ps

module tb_region_track;

    import region_track_pkg::*;

    localparam int MAX_CYCLES = 3000;

    logic                   clk;
    logic                   reset;
    logic                   pixel_valid;
    logic [COORD_W-1:0]     pixel_x;
    logic [COORD_W-1:0]     pixel_y;
    logic [CAM_W-1:0]       pixel_data;
    logic [PIX_W-1:0]       brightness;
    logic                   mask_mode;
    logic                   skin;
    logic                   frame_vsync;
    logic [COORD_W-1:0]     box_min_x [NUM_REGIONS];
    logic [COORD_W-1:0]     box_max_x [NUM_REGIONS];
    logic [COORD_W-1:0]     box_min_y [NUM_REGIONS];
    logic [COORD_W-1:0]     box_max_y [NUM_REGIONS];
    logic [COORD_W-1:0]     draw_x;
    logic [COORD_W-1:0]     draw_y;
    logic [PIX_W-1:0]       fb_pixel;
    logic [THRESH_W-1:0]    area_thresh;
    logic                   highlight;
    logic                   fb_we;
    logic [ADDR_W-1:0]      fb_addr;
    logic [PIX_W-1:0]       fb_data;
    logic [PIX_W-1:0]       red;
    logic [PIX_W-1:0]       green;
    logic [PIX_W-1:0]       blue;
    logic [31:0]            lcg_state;
    int                     cycle_cnt = 0;

    region_track_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .pixel_valid_i (pixel_valid),
        .pixel_x_i     (pixel_x),
        .pixel_y_i     (pixel_y),
        .pixel_data_i  (pixel_data),
        .brightness_i  (brightness),
        .mask_mode_i   (mask_mode),
        .skin_i        (skin),
        .frame_vsync_i (frame_vsync),
        .box_min_x_i   (box_min_x),
        .box_max_x_i   (box_max_x),
        .box_min_y_i   (box_min_y),
        .box_max_y_i   (box_max_y),
        .draw_x_i      (draw_x),
        .draw_y_i      (draw_y),
        .fb_pixel_i    (fb_pixel),
        .area_thresh_i (area_thresh),
        .highlight_i   (highlight),
        .fb_we_o       (fb_we),
        .fb_addr_o     (fb_addr),
        .fb_data_o     (fb_data),
        .red_o         (red),
        .green_o       (green),
        .blue_o        (blue)
    );

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_fail("Timeout: the tests did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task report_fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task check_pix(input string name, input logic [PIX_W-1:0] got, input logic [PIX_W-1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task check_addr(input string name, input logic [ADDR_W-1:0] got,
                    input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task pulse_vsync();
        @(negedge clk);
        frame_vsync = 1'b1;
        wait_cycles(3);
        frame_vsync = 1'b0;
        wait_cycles(3);
    endtask

    // Paint means a red outline is expected
    task check_draw(input int x, input int y, input logic paint);
        logic [31:0] r;
        logic [PIX_W-1:0] pix;
        r = lcg_next();
        pix = r[22:16];
        draw_x = COORD_W'(x);
        draw_y = COORD_W'(y);
        fb_pixel = pix;
        @(negedge clk);
        check_pix("red_o", red, paint ? 7'h7F : pix);
        check_pix("green_o", green, paint ? 7'h00 : pix);
        check_pix("blue_o", blue, paint ? 7'h00 : pix);
    endtask

    // Random pixels with idle gaps and a check one cycle later
    task run_stream(input int n_valid, input logic mask);
        logic [31:0] r1;
        logic [31:0] r2;
        logic v;
        int sent;
        int x;
        int y;
        int prod;
        logic [PIX_W-1:0] exp_data;
        sent = 0;
        @(negedge clk);
        mask_mode = mask;
        while (sent < n_valid) begin
            r1 = lcg_next();
            r2 = lcg_next();
            v = (r1[31:30] != 2'b00);
            x = int'(r1[25:10]) % 640;
            y = int'(r1[8:0]) % 480;
            pixel_valid = v;
            pixel_x = COORD_W'(x);
            pixel_y = COORD_W'(y);
            pixel_data = r2[15:8];
            brightness = r2[22:16];
            skin = r2[24];
            prod = int'(r2[15:9]) * int'(r2[22:16]);
            if (mask) begin
                exp_data = r2[24] ? 7'h00 : 7'h3F;
            end else begin
                exp_data = PIX_W'(prod / 128);
            end
            @(negedge clk);
            check_bit("fb_we_o", fb_we, v);
            if (v) begin
                check_addr("fb_addr_o", fb_addr, ADDR_W'(y * 640 + x));
                check_pix("fb_data_o", fb_data, exp_data);
                sent++;
            end
        end
        pixel_valid = 1'b0;
        @(negedge clk);
        check_bit("fb_we_o", fb_we, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task test_reset_state();
        // Busy inputs during reset so only the reset keeps the outputs at zero
        pixel_valid = 1'b1;
        fb_pixel = 7'h2A;
        wait_cycles(10);
        check_bit("fb_we_o", fb_we, 1'b0);
        check_pix("red_o", red, 7'h00);
        check_pix("green_o", green, 7'h00);
        check_pix("blue_o", blue, 7'h00);
        reset = 1'b0;
        pixel_valid = 1'b0;
        highlight = 1'b1;
        // No box latched yet
        check_draw(0, 0, 1'b0);
        check_draw(641, 0, 1'b0);
        check_draw(641, 641, 1'b0);
        check_draw(320, 240, 1'b0);
    endtask

    task test_brightness_write();
        run_stream(20, 1'b0);
    endtask

    task test_mask_write();
        run_stream(12, 1'b1);
    endtask

    task test_latch_cadence();
        // 20 by 10 box in region 0
        box_min_x[0] = 10'd100;
        box_max_x[0] = 10'd119;
        box_min_y[0] = 10'd50;
        box_max_y[0] = 10'd59;
        repeat (4) pulse_vsync();
        wait_cycles(8);
        check_draw(100, 50, 1'b0);
        pulse_vsync();
        wait_cycles(8);
        check_draw(100, 50, 1'b1);
        check_draw(119, 55, 1'b1);
        check_draw(110, 59, 1'b1);
        check_draw(110, 55, 1'b0);
        check_draw(99, 50, 1'b0);
    endtask

    task test_area_filter();
        // 3 by 4 box and a region with no pixels seen
        box_min_x[0] = 10'd300;
        box_max_x[0] = 10'd302;
        box_min_y[0] = 10'd100;
        box_max_y[0] = 10'd103;
        box_min_x[1] = 10'd641;
        box_max_x[1] = 10'd660;
        box_min_y[1] = 10'd200;
        box_max_y[1] = 10'd210;
        repeat (5) pulse_vsync();
        wait_cycles(8);
        check_draw(300, 100, 1'b0);
        area_thresh = 15'd12;
        wait_cycles(2);
        check_draw(300, 100, 1'b1);
        check_draw(302, 103, 1'b1);
        check_draw(641, 200, 1'b0);
        area_thresh = 15'd1;
        wait_cycles(2);
        check_draw(641, 200, 1'b0);
        check_draw(660, 205, 1'b0);
        area_thresh = 15'd13;
        wait_cycles(2);
        check_draw(300, 100, 1'b0);
    endtask

    task test_highlight_off();
        area_thresh = 15'd12;
        highlight = 1'b0;
        wait_cycles(2);
        check_draw(300, 100, 1'b0);
        check_draw(302, 101, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lcg_state = 32'h6137_990a;
        pixel_valid = 1'b0;
        pixel_x = '0;
        pixel_y = '0;
        pixel_data = '0;
        brightness = '0;
        mask_mode = 1'b0;
        skin = 1'b0;
        frame_vsync = 1'b0;
        draw_x = '0;
        draw_y = '0;
        fb_pixel = '0;
        area_thresh = '0;
        highlight = 1'b0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            box_min_x[i] = 10'd641;
            box_max_x[i] = '0;
            box_min_y[i] = 10'd641;
            box_max_y[i] = '0;
        end
        test_reset_state();
        test_brightness_write();
        test_mask_write();
        test_latch_cadence();
        test_area_filter();
        test_highlight_off();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
